//--- source/rip_pkg.sv
package rip_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;
    localparam int imem_addr_width = $clog2(imem_depth);
    localparam int dmem_addr_width = $clog2(dmem_depth);
    localparam int result_reg = 3;

    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;
    localparam logic [2:0] funct3_beq = 3'b000;
    localparam logic [2:0] funct3_bne = 3'b001;
    localparam logic [2:0] funct3_word = 3'b010;
    localparam logic [6:0] funct7_sub = 7'b0100000;
    localparam logic [11:0] funct12_ebreak = 12'h001;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_lw,
        op_sw,
        op_beq,
        op_bne,
        op_jal,
        op_ebreak
    } op_e;

    typedef enum logic [1:0] {
        stage_invalid,
        stage_stall,
        stage_ready
    } stage_state_e;

    typedef enum logic {
        mode_idle,
        mode_running
    } core_mode_e;

endpackage

//--- source/rip_regfile.sv
module rip_regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rip_pkg::reg_addr_width-1:0] rs1_num,
    input  logic [rip_pkg::reg_addr_width-1:0] rs2_num,
    input  logic                               wen,
    input  logic [rip_pkg::reg_addr_width-1:0] wd_num,
    input  logic [rip_pkg::xlen-1:0]           wd_data,
    output logic [rip_pkg::xlen-1:0]           rs1_data,
    output logic [rip_pkg::xlen-1:0]           rs2_data,
    output logic [rip_pkg::xlen-1:0]           result
);
    import rip_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_width];
    logic            write_live;

    assign write_live = wen && wd_num != '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (write_live) begin
            regs[wd_num] <= wd_data;
        end
    end

    // same-cycle write passes through
    assign rs1_data = (rs1_num == '0) ? '0 :
                      (write_live && wd_num == rs1_num) ? wd_data : regs[rs1_num];
    assign rs2_data = (rs2_num == '0) ? '0 :
                      (write_live && wd_num == rs2_num) ? wd_data : regs[rs2_num];
    assign result = regs[result_reg];

    assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("x0 holds a non-zero value");

endmodule

//--- source/rip_fetch.sv
module rip_fetch (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                busy,
    input  logic                                prog_we,
    input  logic [rip_pkg::imem_addr_width-1:0] prog_addr,
    input  logic [rip_pkg::xlen-1:0]            prog_data,
    input  logic                                stall,
    input  logic                                redirect,
    input  logic [rip_pkg::xlen-1:0]            redirect_target,
    output logic                                fetch_valid,
    output logic [rip_pkg::xlen-1:0]            fetch_pc,
    output logic [rip_pkg::xlen-1:0]            fetch_inst
);
    import rip_pkg::*;

    logic [xlen-1:0] imem [imem_depth];
    logic [xlen-1:0] pc;
    logic            advance;

    assign advance = busy && !redirect && !stall;

    // program load only while the core is idle
    always_ff @(posedge clk) begin
        if (prog_we && !busy) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
            fetch_valid <= 1'b0;
        end else if (!busy) begin
            pc <= '0;
            fetch_valid <= 1'b0;
        end else if (redirect) begin
            pc <= redirect_target;
            fetch_valid <= 1'b0;
        end else if (!stall) begin
            pc <= pc + xlen'(4);
            fetch_valid <= 1'b1;
        end
    end

    // one-cycle instruction read
    always_ff @(posedge clk) begin
        if (advance) begin
            fetch_inst <= imem[pc[imem_addr_width+1:2]];
            fetch_pc <= pc;
        end
    end

    // targets come from execute
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc);

endmodule

//--- source/rip_decode.sv
module rip_decode (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               fetch_valid,
    input  logic [rip_pkg::xlen-1:0]           fetch_pc,
    input  logic [rip_pkg::xlen-1:0]           fetch_inst,
    input  logic                               flush,
    input  logic [rip_pkg::xlen-1:0]           rs1_data,
    input  logic [rip_pkg::xlen-1:0]           rs2_data,
    input  logic [rip_pkg::xlen-1:0]           ex_result,
    input  logic [rip_pkg::reg_addr_width-1:0] ex_rd,
    input  logic                               ex_write,
    input  logic                               ex_is_load,
    input  logic [rip_pkg::reg_addr_width-1:0] ma_rd,
    input  logic [rip_pkg::xlen-1:0]           ma_data,
    input  logic                               ma_write,
    input  logic [rip_pkg::reg_addr_width-1:0] awb_rd,
    input  logic [rip_pkg::xlen-1:0]           awb_data,
    input  logic                               awb_write,
    output logic [rip_pkg::reg_addr_width-1:0] rs1_num,
    output logic [rip_pkg::reg_addr_width-1:0] rs2_num,
    output logic                               stall,
    output logic                               de_valid,
    output rip_pkg::op_e                       de_op,
    output logic [rip_pkg::xlen-1:0]           de_pc,
    output logic [rip_pkg::xlen-1:0]           de_rs1,
    output logic [rip_pkg::xlen-1:0]           de_rs2,
    output logic [rip_pkg::xlen-1:0]           de_imm,
    output logic [rip_pkg::reg_addr_width-1:0] de_rd
);
    import rip_pkg::*;

    op_e                       op;
    logic [xlen-1:0]           imm;
    logic [2:0]                funct3;
    logic                      d_valid;
    logic [reg_addr_width-1:0] d_rs1_num;
    logic [reg_addr_width-1:0] d_rs2_num;
    logic [xlen-1:0]           d_rs1_reg;
    logic [xlen-1:0]           d_rs2_reg;
    stage_state_e              de_state;

    // nearest producer wins
    function automatic logic [xlen-1:0] forward(input logic [reg_addr_width-1:0] num,
                                                input logic [xlen-1:0] reg_value);
        if (ex_write && ex_rd == num) return ex_result;
        if (ma_write && ma_rd == num) return ma_data;
        if (awb_write && awb_rd == num) return awb_data;
        return reg_value;
    endfunction

    assign rs1_num = fetch_inst[19:15];
    assign rs2_num = fetch_inst[24:20];
    assign funct3 = fetch_inst[14:12];

    always_comb begin
        op = op_nop;
        imm = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
        case (opcode_e'(fetch_inst[6:0]))
            opc_op: begin
                case (funct3)
                    funct3_add_sub: op = (fetch_inst[31:25] == funct7_sub) ? op_sub : op_add;
                    funct3_xor:     op = op_xor;
                    funct3_or:      op = op_or;
                    funct3_and:     op = op_and;
                    default:        op = op_nop;
                endcase
            end
            opc_op_imm: if (funct3 == funct3_add_sub) op = op_addi;
            opc_load:   if (funct3 == funct3_word) op = op_lw;
            opc_store: begin
                if (funct3 == funct3_word) op = op_sw;
                imm = {{20{fetch_inst[31]}}, fetch_inst[31:25], fetch_inst[11:7]};
            end
            opc_branch: begin
                if (funct3 == funct3_beq) op = op_beq;
                if (funct3 == funct3_bne) op = op_bne;
                imm = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
                       fetch_inst[11:8], 1'b0};
            end
            opc_jal: begin
                op = op_jal;
                imm = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
                       fetch_inst[30:21], 1'b0};
            end
            opc_system: begin
                if (funct3 == 3'b000 && fetch_inst[31:20] == funct12_ebreak) op = op_ebreak;
            end
            default: op = op_nop;
        endcase
    end

    // load in execute feeding the held instruction
    assign stall = d_valid && ex_is_load && ex_rd != '0 &&
                   (ex_rd == d_rs1_num || ex_rd == d_rs2_num);

    always_comb begin
        if (!d_valid) de_state = stage_invalid;
        else if (stall) de_state = stage_stall;
        else de_state = stage_ready;
    end

    assign de_valid = (de_state == stage_ready);

    always_comb begin
        de_rs1 = forward(d_rs1_num, d_rs1_reg);
        de_rs2 = forward(d_rs2_num, d_rs2_reg);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (flush) begin
            d_valid <= 1'b0;
        end else if (!stall) begin
            d_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            de_op <= op;
            de_pc <= fetch_pc;
            de_imm <= imm;
            de_rd <= fetch_inst[11:7];
            d_rs1_num <= rs1_num;
            d_rs2_num <= rs2_num;
            d_rs1_reg <= rs1_data;
            d_rs2_reg <= rs2_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) d_valid |-> !(stall && flush))
        else $error("decode stalled and flushed in the same cycle");

endmodule

//--- source/rip_execute.sv
module rip_execute (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               run,
    input  logic                               de_valid,
    input  rip_pkg::op_e                       de_op,
    input  logic [rip_pkg::xlen-1:0]           de_pc,
    input  logic [rip_pkg::xlen-1:0]           de_rs1,
    input  logic [rip_pkg::xlen-1:0]           de_rs2,
    input  logic [rip_pkg::xlen-1:0]           de_imm,
    input  logic [rip_pkg::reg_addr_width-1:0] de_rd,
    output logic                               busy,
    output logic                               redirect,
    output logic [rip_pkg::xlen-1:0]           redirect_target,
    output logic                               ex_valid,
    output rip_pkg::op_e                       ex_op,
    output logic [rip_pkg::xlen-1:0]           ex_result,
    output logic [rip_pkg::reg_addr_width-1:0] ex_rd,
    output logic [rip_pkg::xlen-1:0]           ex_store_data,
    output logic                               ex_write,
    output logic                               ex_is_load
);
    import rip_pkg::*;

    core_mode_e      mode;
    logic            live;
    logic            writes_rd;
    logic            taken;
    logic [xlen-1:0] alu;

    // anything behind an ebreak dies here
    assign live = de_valid && mode == mode_running;

    always_comb begin
        case (de_op)
            op_add:                alu = de_rs1 + de_rs2;
            op_sub:                alu = de_rs1 - de_rs2;
            op_and:                alu = de_rs1 & de_rs2;
            op_or:                 alu = de_rs1 | de_rs2;
            op_xor:                alu = de_rs1 ^ de_rs2;
            op_addi, op_lw, op_sw: alu = de_rs1 + de_imm;
            op_jal:                alu = de_pc + xlen'(4);
            default:               alu = '0;
        endcase
    end

    assign writes_rd = de_op inside {op_add, op_sub, op_and, op_or, op_xor,
                                     op_addi, op_lw, op_jal};

    always_comb begin
        case (de_op)
            op_beq:  taken = (de_rs1 == de_rs2);
            op_bne:  taken = (de_rs1 != de_rs2);
            op_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // not-taken is the fall-through path
    assign redirect = live && taken;
    assign redirect_target = de_pc + de_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_write <= 1'b0;
            ex_is_load <= 1'b0;
        end else begin
            ex_valid <= live;
            ex_write <= live && writes_rd && de_rd != '0;
            ex_is_load <= live && de_op == op_lw;
        end
    end

    always_ff @(posedge clk) begin
        ex_op <= de_op;
        ex_result <= alu;
        ex_rd <= de_rd;
        ex_store_data <= de_rs2;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode <= mode_idle;
        end else begin
            case (mode)
                mode_idle:    if (run) mode <= mode_running;
                mode_running: if (live && de_op == op_ebreak) mode <= mode_idle;
                default:      mode <= mode_idle;
            endcase
        end
    end

    assign busy = (mode == mode_running);

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(de_valid && de_op == op_ebreak))
        else $error("busy dropped without an ebreak in execute");

endmodule

//--- source/rip_data_memory.sv
module rip_data_memory (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               ex_valid,
    input  rip_pkg::op_e                       ex_op,
    input  logic [rip_pkg::xlen-1:0]           ex_result,
    input  logic [rip_pkg::reg_addr_width-1:0] ex_rd,
    input  logic [rip_pkg::xlen-1:0]           ex_store_data,
    input  logic                               ex_write,
    input  logic                               ex_is_load,
    output logic [rip_pkg::reg_addr_width-1:0] ma_rd,
    output logic [rip_pkg::xlen-1:0]           ma_data,
    output logic                               ma_write,
    output logic                               wb_wen,
    output logic [rip_pkg::reg_addr_width-1:0] wb_rd,
    output logic [rip_pkg::xlen-1:0]           wb_data,
    output logic [rip_pkg::reg_addr_width-1:0] awb_rd,
    output logic [rip_pkg::xlen-1:0]           awb_data,
    output logic                               awb_write
);
    import rip_pkg::*;

    logic [xlen-1:0] dmem [dmem_depth];
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] m_result;
    logic            m_is_load;

    always_ff @(posedge clk) begin
        if (ex_valid && ex_op == op_sw) begin
            dmem[ex_result[dmem_addr_width+1:2]] <= ex_store_data;
        end
        load_data <= dmem[ex_result[dmem_addr_width+1:2]];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_wen <= 1'b0;
            awb_write <= 1'b0;
        end else begin
            wb_wen <= ex_write;
            awb_write <= wb_wen;
        end
    end

    always_ff @(posedge clk) begin
        m_result <= ex_result;
        m_is_load <= ex_is_load;
        wb_rd <= ex_rd;
        awb_rd <= wb_rd;
        awb_data <= wb_data;
    end

    assign wb_data = m_is_load ? load_data : m_result;

    // memory-stage forwarding taps the value being written back
    assign ma_rd = wb_rd;
    assign ma_data = wb_data;
    assign ma_write = wb_wen;

endmodule

//--- source/rip_core.sv
module rip_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                run,
    output logic                                busy,
    input  logic                                prog_we,
    input  logic [rip_pkg::imem_addr_width-1:0] prog_addr,
    input  logic [rip_pkg::xlen-1:0]            prog_data,
    output logic [rip_pkg::xlen-1:0]            result
);
    import rip_pkg::*;

    logic                      stall;
    logic                      redirect;
    logic [xlen-1:0]           redirect_target;
    logic                      fetch_valid;
    logic [xlen-1:0]           fetch_pc;
    logic [xlen-1:0]           fetch_inst;
    logic [reg_addr_width-1:0] rs1_num;
    logic [reg_addr_width-1:0] rs2_num;
    logic [xlen-1:0]           rs1_data;
    logic [xlen-1:0]           rs2_data;
    logic                      de_valid;
    op_e                       de_op;
    logic [xlen-1:0]           de_pc;
    logic [xlen-1:0]           de_rs1;
    logic [xlen-1:0]           de_rs2;
    logic [xlen-1:0]           de_imm;
    logic [reg_addr_width-1:0] de_rd;
    logic                      ex_valid;
    op_e                       ex_op;
    logic [xlen-1:0]           ex_result;
    logic [reg_addr_width-1:0] ex_rd;
    logic [xlen-1:0]           ex_store_data;
    logic                      ex_write;
    logic                      ex_is_load;
    logic [reg_addr_width-1:0] ma_rd;
    logic [xlen-1:0]           ma_data;
    logic                      ma_write;
    logic                      wb_wen;
    logic [reg_addr_width-1:0] wb_rd;
    logic [xlen-1:0]           wb_data;
    logic [reg_addr_width-1:0] awb_rd;
    logic [xlen-1:0]           awb_data;
    logic                      awb_write;

    rip_fetch fetch (
        .clk(clk), .rst_n(rst_n), .busy(busy),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .stall(stall), .redirect(redirect), .redirect_target(redirect_target),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_inst(fetch_inst)
    );

    rip_decode decode (
        .clk(clk), .rst_n(rst_n),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_inst(fetch_inst),
        .flush(redirect), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_result(ex_result), .ex_rd(ex_rd), .ex_write(ex_write), .ex_is_load(ex_is_load),
        .ma_rd(ma_rd), .ma_data(ma_data), .ma_write(ma_write),
        .awb_rd(awb_rd), .awb_data(awb_data), .awb_write(awb_write),
        .rs1_num(rs1_num), .rs2_num(rs2_num), .stall(stall),
        .de_valid(de_valid), .de_op(de_op), .de_pc(de_pc), .de_rs1(de_rs1),
        .de_rs2(de_rs2), .de_imm(de_imm), .de_rd(de_rd)
    );

    rip_regfile regfile (
        .clk(clk), .rst_n(rst_n), .rs1_num(rs1_num), .rs2_num(rs2_num),
        .wen(wb_wen), .wd_num(wb_rd), .wd_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .result(result)
    );

    rip_execute execute (
        .clk(clk), .rst_n(rst_n), .run(run),
        .de_valid(de_valid), .de_op(de_op), .de_pc(de_pc), .de_rs1(de_rs1),
        .de_rs2(de_rs2), .de_imm(de_imm), .de_rd(de_rd),
        .busy(busy), .redirect(redirect), .redirect_target(redirect_target),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_result(ex_result), .ex_rd(ex_rd),
        .ex_store_data(ex_store_data), .ex_write(ex_write), .ex_is_load(ex_is_load)
    );

    rip_data_memory data_memory (
        .clk(clk), .rst_n(rst_n),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_result(ex_result), .ex_rd(ex_rd),
        .ex_store_data(ex_store_data), .ex_write(ex_write), .ex_is_load(ex_is_load),
        .ma_rd(ma_rd), .ma_data(ma_data), .ma_write(ma_write),
        .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_data(wb_data),
        .awb_rd(awb_rd), .awb_data(awb_data), .awb_write(awb_write)
    );

endmodule

//--- bench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 10;
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // synchronous reset, released on an edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- bench/tb_rip_core.sv
module tb_rip_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] ebreak_word = 32'h0010_0073;
    localparam int random_seed = 51966;

    logic                                clk;
    logic                                rst_n;
    logic                                run;
    logic                                busy;
    logic                                prog_we;
    logic [rip_pkg::imem_addr_width-1:0] prog_addr;
    logic [31:0]                         prog_data;
    logic [31:0]                         result;

    logic        reset_check;
    logic        result_check;
    logic [31:0] expected_result;
    int          value_errors;
    int          control_errors;
    int          cycle_count;
    int          cycle_limit = 0;

    logic [31:0] chain_prog[$];
    logic [31:0] load_use_prog[$];
    logic [31:0] branch_prog[$];
    logic [31:0] rerun_prog[$];
    logic [31:0] chain_expected;
    logic [31:0] load_use_expected;
    logic [31:0] branch_expected;
    logic [31:0] rerun_expected;

    tb_clock clock_gen (.clk(clk), .rst_n(rst_n));

    rip_core DUT (
        .clk(clk), .rst_n(rst_n), .run(run), .busy(busy),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data), .result(result)
    );

    function automatic logic [31:0] op_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_word(input logic [6:0] opcode, input logic [2:0] funct3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return imm_word(7'b0010011, 3'b000, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] funct3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_word(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic build_programs;
        logic [11:0] a, b, c, v, w, k;
        logic [31:0] x5, x6, x7, x8, x9, x10, x11;
        a = 12'($urandom % 2048);
        b = 12'($urandom % 2048);
        c = 12'($urandom % 2048);
        v = 12'($urandom % 2048);
        w = 12'($urandom % 2048);
        k = 12'($urandom % 2048);
        // each step reads the one before it
        chain_prog.push_back(addi_word(5'd5, 5'd0, a));
        chain_prog.push_back(addi_word(5'd6, 5'd5, b));
        chain_prog.push_back(op_word(7'b0000000, 3'b000, 5'd7, 5'd6, 5'd5));
        chain_prog.push_back(addi_word(5'd11, 5'd7, c));
        chain_prog.push_back(op_word(7'b0100000, 3'b000, 5'd8, 5'd11, 5'd6));
        chain_prog.push_back(op_word(7'b0000000, 3'b111, 5'd9, 5'd8, 5'd7));
        chain_prog.push_back(op_word(7'b0000000, 3'b110, 5'd10, 5'd9, 5'd11));
        chain_prog.push_back(op_word(7'b0000000, 3'b100, 5'd3, 5'd10, 5'd6));
        chain_prog.push_back(ebreak_word);
        x5 = 32'(a);
        x6 = x5 + 32'(b);
        x7 = x6 + x5;
        x11 = x7 + 32'(c);
        x8 = x11 - x6;
        x9 = x8 & x7;
        x10 = x9 | x11;
        chain_expected = x10 ^ x6;
        // the add right behind the lw needs the load value
        // x8 reaches the stalled add from after write-back
        load_use_prog.push_back(addi_word(5'd5, 5'd0, v));
        load_use_prog.push_back(store_word(5'd5, 5'd0, 12'd8));
        load_use_prog.push_back(addi_word(5'd8, 5'd0, w));
        load_use_prog.push_back(imm_word(7'b0000011, 3'b010, 5'd7, 5'd0, 12'd8));
        load_use_prog.push_back(op_word(7'b0000000, 3'b000, 5'd3, 5'd7, 5'd8));
        load_use_prog.push_back(ebreak_word);
        load_use_expected = 32'(v) + 32'(w);
        branch_prog.push_back(addi_word(5'd3, 5'd0, 12'd1));
        branch_prog.push_back(addi_word(5'd5, 5'd0, 12'd5));
        branch_prog.push_back(branch_word(3'b001, 5'd5, 5'd0, 13'd8));
        branch_prog.push_back(addi_word(5'd3, 5'd3, 12'd2));
        branch_prog.push_back(addi_word(5'd3, 5'd3, 12'd4));
        branch_prog.push_back(branch_word(3'b000, 5'd5, 5'd0, 13'd8));
        branch_prog.push_back(addi_word(5'd3, 5'd3, 12'd8));
        branch_prog.push_back(jump_word(5'd0, 21'd8));
        branch_prog.push_back(addi_word(5'd3, 5'd3, 12'd16));
        branch_prog.push_back(addi_word(5'd3, 5'd3, 12'd32));
        branch_prog.push_back(ebreak_word);
        // bne skips the +2, beq falls through to +8, jal skips the +16
        branch_expected = 32'd1 + 32'd4 + 32'd8 + 32'd32;
        rerun_prog.push_back(addi_word(5'd5, 5'd0, k));
        rerun_prog.push_back(addi_word(5'd6, 5'd5, 12'd1));
        rerun_prog.push_back(op_word(7'b0000000, 3'b000, 5'd3, 5'd6, 5'd5));
        rerun_prog.push_back(ebreak_word);
        rerun_expected = 32'(k) * 2 + 32'd1;
    endtask

    task automatic load_program(input logic [31:0] words[$]);
        foreach (words[i]) begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= rip_pkg::imem_addr_width'(i);
            prog_data <= words[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic run_program(input logic [31:0] expected, input bit disturb);
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        while (!busy) @(posedge clk);
        if (disturb) begin
            // both strobes must be ignored mid-run
            prog_we <= 1'b1;
            prog_addr <= rip_pkg::imem_addr_width'(2);
            prog_data <= addi_word(5'd3, 5'd0, 12'd0);
            run <= 1'b1;
            @(posedge clk);
            prog_we <= 1'b0;
            run <= 1'b0;
        end
        while (busy) @(posedge clk);
        // memory access and write-back drain
        repeat (2) @(posedge clk);
        expected_result <= expected;
        result_check <= 1'b1;
        @(posedge clk);
        result_check <= 1'b0;
    endtask

    initial begin
        void'($urandom(random_seed));
        run <= 1'b0;
        prog_we <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        reset_check <= 1'b0;
        result_check <= 1'b0;
        expected_result <= '0;
        value_errors = 0;
        control_errors = 0;
        build_programs();
        cycle_limit = 4 * (chain_prog.size() + load_use_prog.size() + branch_prog.size()
                           + rerun_prog.size()) + 100;
        @(posedge clk);
        while (!rst_n) @(posedge clk);
        reset_check <= 1'b1;
        @(posedge clk);
        reset_check <= 1'b0;
        load_program(chain_prog);
        run_program(chain_expected, 1'b0);
        load_program(load_use_prog);
        run_program(load_use_expected, 1'b0);
        load_program(branch_prog);
        run_program(branch_expected, 1'b0);
        load_program(rerun_prog);
        run_program(rerun_expected, 1'b1);
        run_program(rerun_expected, 1'b0);
        repeat (2) @(posedge clk);
        $display("value errors: %0d, control errors: %0d", value_errors, control_errors);
        if (value_errors == 0 && control_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the runs did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        reset_check |-> !busy && result == '0)
        else begin
            value_errors++;
            $display("ERROR at %0t: after reset busy=%b result=%h", $time,
                     $sampled(busy), $sampled(result));
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        result_check |-> result == expected_result)
        else begin
            value_errors++;
            $display("ERROR at %0t: result %h, expected %h", $time,
                     $sampled(result), $sampled(expected_result));
        end

    assert property (@(posedge clk) disable iff (!rst_n) run && !busy |=> busy)
        else begin
            control_errors++;
            $display("busy did not rise after run was given at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) run && busy |=> busy)
        else begin
            control_errors++;
            $display("a run strobe during a run stopped the core at %0t", $time);
        end

endmodule

//--- tb.f
source/rip_pkg.sv
source/rip_regfile.sv
source/rip_fetch.sv
source/rip_decode.sv
source/rip_execute.sv
source/rip_data_memory.sv
source/rip_core.sv
bench/tb_clock.sv
bench/tb_rip_core.sv
